// ==== Makefile ====
TOP = tb_turf_regs
LOG = sim.log

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

obj_dir/V$(TOP): sim.f hdl/turf_regs_cfg.svh $(wildcard hdl/*.sv) $(wildcard bench/*.sv)
	verilator --binary --timing --assert -f sim.f --top-module $(TOP)

lint:
	verilator --lint-only +incdir+hdl hdl/turf_regs_pkg.sv hdl/turf_reg_intercon.sv \
		hdl/turf_id_ctrl.sv hdl/crate_bridge.sv hdl/turf_regs_top.sv \
		--top-module turf_regs_top

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/tb_turf_regs.sv ====
`timescale 1ns/1ns
`include "turf_regs_cfg.svh"

module tb_turf_regs
    import turf_regs_pkg::*;
();

    // Tests take roughly 300 cycles
    localparam int MAX_CYCLES = 5000;
    localparam int ACK_LIMIT  = `BRIDGE_TIMEOUT + 8;
    localparam logic [`WB_ADR_W-1:0] RSVD_ADDR    = 28'h0004000;
    localparam logic [`WB_ADR_W-1:0] RSVD_ADDR_HI = 28'h000C008;

    logic                  ps_clk;
    logic                  reset_i;
    wb_req_t               host_req;
    wb_rsp_t               host_rsp;
    wb_req_t               crate_req;
    wb_rsp_t               crate_rsp = '0;
    logic [`NUM_LINKS-1:0] link_up;
    logic [`WB_DAT_W/8-1:0] host_sel;

    // Crate slave model state
    logic [`WB_DAT_W-1:0]  crate_mem [16];
    logic [`WB_ADR_W-1:0]  crate_last_adr;
    logic [`WB_DAT_W/8-1:0] crate_last_sel;
    int                    crate_cycles = 0;
    int                    crate_wait;
    int                    crate_delay;
    logic                  crate_never;

    int                    checks = 0;
    int                    errors = 0;
    int                    cycle_count = 0;

    turf_regs_top UUT (
        .ps_clk      (ps_clk),
        .reset_i     (reset_i),
        .host_req_i  (host_req),
        .host_rsp_o  (host_rsp),
        .crate_req_o (crate_req),
        .crate_rsp_i (crate_rsp),
        .link_up_i   (link_up)
    );

    always #20 ps_clk = ~ps_clk;

    always @(posedge ps_clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Run stopped after %0d cycles, tests did not finish", cycle_count);
            $display("Checks run: %0d, errors: %0d", checks, errors);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Crate slave model answering on the falling edge
    //////////////////////////////////////////////////////////////////////

    always @(negedge ps_clk) begin
        if (reset_i) begin
            for (int i = 0; i < 16; i++) begin
                crate_mem[i] = 32'hC0DE0000 | 32'(i);
            end
            crate_rsp  = '0;
            crate_wait = 0;
        end else if (crate_req.cyc && crate_req.stb && !crate_rsp.ack) begin
            // First cycle of a crate access
            if (crate_wait == 0) begin
                crate_cycles++;
                crate_last_adr = crate_req.adr;
                crate_last_sel = crate_req.sel;
            end
            if (!crate_never && crate_wait >= crate_delay) begin
                crate_rsp.ack = 1'b1;
                if (crate_req.we) begin
                    crate_mem[crate_req.adr[5:2]] = crate_req.dat;
                    crate_rsp.dat = '0;
                end else begin
                    crate_rsp.dat = crate_mem[crate_req.adr[5:2]];
                end
                crate_wait = 0;
            end else begin
                crate_wait++;
            end
        end else begin
            crate_rsp.ack = 1'b0;
            crate_wait    = 0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [`WB_ADR_W-1:0] reg_addr(input int offset);
        return `WB_ADR_W'(offset) << 2;
    endfunction

    function automatic logic [`WB_ADR_W-1:0] crate_addr(input logic [`WB_ADR_W-1:0] offs);
        return (`WB_ADR_W'(1) << `CRATE_SEL_BIT) | offs;
    endfunction

    // Type in bits 1:0, link in bits 3:2
    function automatic logic [31:0] ctrl_word(input bridge_type_e t, input logic [1:0] link);
        return {28'd0, link, t};
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic wb_access(input logic [`WB_ADR_W-1:0] adr, input logic we,
                             input logic [31:0] wdat, output logic [31:0] rdat);
        int waited;
        waited       = 0;
        host_req.cyc = 1'b1;
        host_req.stb = 1'b1;
        host_req.we  = we;
        host_req.adr = adr;
        host_req.dat = wdat;
        host_req.sel = host_sel;
        @(negedge ps_clk);
        while (!host_rsp.ack && waited < ACK_LIMIT) begin
            waited++;
            @(negedge ps_clk);
        end
        if (!host_rsp.ack) begin
            $display("Host access to %h got no ack within %0d cycles", adr, ACK_LIMIT);
            errors++;
        end
        rdat = host_rsp.dat;
        // Hold through the edge that samples ack
        @(negedge ps_clk);
        host_req = '0;
        @(negedge ps_clk);
    endtask

    task automatic wb_write(input logic [`WB_ADR_W-1:0] adr, input logic [31:0] wdat);
        logic [31:0] unused;
        wb_access(adr, 1'b1, wdat, unused);
    endtask

    task automatic wb_read(input logic [`WB_ADR_W-1:0] adr, output logic [31:0] rdat);
        wb_access(adr, 1'b0, 32'd0, rdat);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        logic [31:0] rd;
        check("host_rsp.ack", 32'(host_rsp.ack), 32'd0);
        check("crate_req.cyc", 32'(crate_req.cyc), 32'd0);
        wb_read(reg_addr(`REG_BRIDGE_CTRL), rd);
        check("bridge_ctrl", rd, ctrl_word(BRIDGE_NONE, 2'd0));
        wb_read(reg_addr(`REG_BRIDGE_STAT), rd);
        check("bridge_stat", rd, 32'd0);
    endtask

    task automatic test_ident_status();
        logic [31:0] rd;
        int          seen;
        wb_read(reg_addr(`REG_IDENT), rd);
        check("ident", rd, `TURF_IDENT);
        wb_read(reg_addr(`REG_DATEVERSION), rd);
        check("dateversion", rd, `TURF_DATEVERSION);
        link_up = 4'b0110;
        wb_read(reg_addr(`REG_LINK_UP), rd);
        check("link_up", rd, 32'h6);
        link_up = 4'b1011;
        wb_read(reg_addr(`REG_LINK_UP), rd);
        check("link_up", rd, 32'hB);
        wb_write(RSVD_ADDR, $urandom());
        wb_read(RSVD_ADDR, rd);
        check("rsvd_rdata", rd, 32'd0);
        wb_read(RSVD_ADDR_HI, rd);
        check("rsvd_rdata", rd, 32'd0);
        // With the bridge off nothing goes to the crate
        seen = crate_cycles;
        wb_read(crate_addr(28'h8), rd);
        check("crate_none_rdata", rd, 32'd0);
        check("crate_cycles", 32'(crate_cycles - seen), 32'd0);
        wb_read(reg_addr(`REG_BRIDGE_STAT), rd);
        check("bridge_stat", rd, 32'd0);
    endtask

    task automatic test_crate_rw();
        logic [31:0]          rd;
        logic [31:0]          wdata [4];
        logic [`WB_ADR_W-1:0] offs;
        wb_write(reg_addr(`REG_BRIDGE_CTRL), ctrl_word(BRIDGE_LINK, 2'd1));
        wb_read(reg_addr(`REG_BRIDGE_CTRL), rd);
        check("bridge_ctrl", rd, ctrl_word(BRIDGE_LINK, 2'd1));
        for (int i = 0; i < 4; i++) begin
            offs        = `WB_ADR_W'(16 + 4 * i);
            wdata[i]    = $urandom();
            crate_delay = 7 * i;
            // Byte lanes narrow on each write
            host_sel    = 4'hF >> i;
            wb_write(crate_addr(offs), wdata[i]);
            check("crate_adr", 32'(crate_last_adr), 32'(offs));
            check("crate_sel", 32'(crate_last_sel), 32'(host_sel));
            check("crate_mem", crate_mem[offs[5:2]], wdata[i]);
        end
        host_sel    = 4'hF;
        crate_delay = 3;
        for (int i = 0; i < 4; i++) begin
            offs = `WB_ADR_W'(16 + 4 * i);
            wb_read(crate_addr(offs), rd);
            check("crate_rdata", rd, wdata[i]);
        end
        wb_read(reg_addr(`REG_BRIDGE_STAT), rd);
        check("bridge_stat", rd, 32'd0);
    endtask

    task automatic test_invalid_cfg();
        logic [31:0]  rd;
        logic [31:0]  flag;
        int           seen;
        bridge_type_e types [3];
        logic [1:0]   links [3];
        // Link 2 is down in the 1011 pattern
        types = '{BRIDGE_LINK, BRIDGE_RSVD2, BRIDGE_RSVD3};
        links = '{2'd2, 2'd0, 2'd3};
        for (int i = 0; i < 3; i++) begin
            wb_write(reg_addr(`REG_BRIDGE_CTRL), ctrl_word(types[i], links[i]));
            seen = crate_cycles;
            wb_read(crate_addr(28'h20), rd);
            check("crate_invalid_rdata", rd, `ERR_DATA);
            check("crate_cycles", 32'(crate_cycles - seen), 32'd0);
            flag = 32'(1) << (`NUM_LINKS + links[i]);
            wb_read(reg_addr(`REG_BRIDGE_STAT), rd);
            check("bridge_stat", rd, flag);
            wb_write(reg_addr(`REG_BRIDGE_STAT), flag);
            wb_read(reg_addr(`REG_BRIDGE_STAT), rd);
            check("bridge_stat_clr", rd, 32'd0);
        end
    endtask

    task automatic test_timeout();
        logic [31:0] rd;
        logic [31:0] wdata;
        int          seen;
        wb_write(reg_addr(`REG_BRIDGE_CTRL), ctrl_word(BRIDGE_LINK, 2'd3));
        crate_never = 1'b1;
        seen = crate_cycles;
        wb_read(crate_addr(28'h30), rd);
        check("crate_timeout_rdata", rd, `ERR_DATA);
        check("crate_cycles", 32'(crate_cycles - seen), 32'd1);
        wb_read(reg_addr(`REG_BRIDGE_STAT), rd);
        check("bridge_stat", rd, 32'(1) << 3);
        // Crate answers again
        crate_never = 1'b0;
        crate_delay = 5;
        wdata = $urandom();
        wb_write(crate_addr(28'h34), wdata);
        wb_read(crate_addr(28'h34), rd);
        check("crate_rdata", rd, wdata);
        wb_write(reg_addr(`REG_BRIDGE_STAT), 32'h8);
        wb_read(reg_addr(`REG_BRIDGE_STAT), rd);
        check("bridge_stat_clr", rd, 32'd0);
    endtask

    initial begin
        void'($urandom(83));
        ps_clk      = 1'b0;
        reset_i     = 1'b1;
        host_req    = '0;
        host_sel    = 4'hF;
        link_up     = 4'b1011;
        crate_delay = 0;
        crate_never = 1'b0;
        repeat (10) @(negedge ps_clk);
        reset_i = 1'b0;
        @(negedge ps_clk);
        test_reset_state();
        test_ident_status();
        test_crate_rw();
        test_invalid_cfg();
        test_timeout();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== hdl/crate_bridge.sv ====
`timescale 1ns/1ns
`include "turf_regs_cfg.svh"

module crate_bridge
    import turf_regs_pkg::*;
(
    input  logic                  ps_clk,
    input  logic                  reset_i,
    input  wb_req_t               wb_req_i,
    output wb_rsp_t               wb_rsp_o,
    input  bridge_cfg_t           bridge_cfg_i,
    input  logic [`NUM_LINKS-1:0] link_up_i,
    output bridge_err_t           bridge_err_o,
    output wb_req_t               crate_req_o,
    input  wb_rsp_t               crate_rsp_i
);

    localparam int CNT_W = $clog2(`BRIDGE_TIMEOUT);

    bridge_state_e        state_q;
    logic [CNT_W-1:0]     wait_cnt_q;
    logic [`WB_DAT_W-1:0] rdat_q;
    bridge_err_t          err_q;
    logic                 req_valid;
    logic                 cfg_none;
    logic                 cfg_ok;
    logic                 timed_out;

    assign req_valid = wb_req_i.cyc & wb_req_i.stb;

    // Validity of the current configuration
    always_comb begin
        cfg_none = 1'b0;
        cfg_ok   = 1'b0;
        case (bridge_cfg_i.btype)
            BRIDGE_NONE: cfg_none = 1'b1;
            BRIDGE_LINK: cfg_ok   = link_up_i[bridge_cfg_i.link];
            default:     cfg_ok   = 1'b0;
        endcase
    end

    assign timed_out = (wait_cnt_q == CNT_W'(`BRIDGE_TIMEOUT - 1));

    //////////////////////////////////////////////////////////////////////
    // Access FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            state_q    <= IDLE;
            wait_cnt_q <= '0;
            err_q      <= '0;
        end else begin
            err_q.timeout <= 1'b0;
            err_q.invalid <= 1'b0;
            case (state_q)
                IDLE: begin
                    wait_cnt_q <= '0;
                    if (req_valid) begin
                        err_q.link <= bridge_cfg_i.link;
                        if (cfg_ok) begin
                            state_q <= FORWARD;
                        end else begin
                            // NONE answers quietly while other types flag invalid
                            state_q       <= RESPOND;
                            err_q.invalid <= ~cfg_none;
                        end
                    end
                end
                FORWARD: begin
                    if (crate_rsp_i.ack) begin
                        state_q <= RESPOND;
                    end else if (timed_out) begin
                        state_q       <= RESPOND;
                        err_q.timeout <= 1'b1;
                    end else begin
                        wait_cnt_q <= wait_cnt_q + 1'b1;
                    end
                end
                RESPOND: begin
                    state_q <= IDLE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // Host read data
    always_ff @(posedge ps_clk) begin
        if (state_q == IDLE && req_valid) begin
            rdat_q <= cfg_none ? '0 : `ERR_DATA;
        end else if (state_q == FORWARD) begin
            rdat_q <= crate_rsp_i.ack ? crate_rsp_i.dat : `ERR_DATA;
        end
    end

    // Crate offset and payload come straight from the held host request
    always_comb begin
        crate_req_o     = wb_req_i;
        crate_req_o.cyc = (state_q == FORWARD);
        crate_req_o.stb = (state_q == FORWARD);
    end

    assign wb_rsp_o.ack = (state_q == RESPOND);
    assign wb_rsp_o.dat = rdat_q;
    assign bridge_err_o = err_q;

    // The crate cycle only runs under a held host request
    assert property (@(posedge ps_clk) disable iff (reset_i)
        crate_req_o.cyc |-> req_valid);

    assert property (@(posedge ps_clk) disable iff (reset_i)
        $rose(crate_req_o.stb) |-> ##[1:`BRIDGE_TIMEOUT] !crate_req_o.stb);

endmodule

// ==== hdl/turf_id_ctrl.sv ====
`timescale 1ns/1ns
`include "turf_regs_cfg.svh"

module turf_id_ctrl
    import turf_regs_pkg::*;
(
    input  logic                  ps_clk,
    input  logic                  reset_i,
    input  wb_req_t               wb_req_i,
    output wb_rsp_t               wb_rsp_o,
    input  logic [`NUM_LINKS-1:0] link_up_i,
    input  bridge_err_t           bridge_err_i,
    output bridge_cfg_t           bridge_cfg_o
);

    logic                         access;
    logic                         wr_en;
    logic [`IDCTL_SEL_LSB-3:0]    word_idx;
    logic                         ack_q;
    logic [`WB_DAT_W-1:0]         dat_q;
    logic [`WB_DAT_W-1:0]         rdata;
    bridge_cfg_t                  cfg_q;
    logic [`NUM_LINKS-1:0]        tout_flags_q;
    logic [`NUM_LINKS-1:0]        inv_flags_q;
    logic [`NUM_LINKS-1:0]        err_link_mask;
    logic [`NUM_LINKS-1:0]        tout_clr;
    logic [`NUM_LINKS-1:0]        inv_clr;

    // Word index from the byte address
    assign word_idx = wb_req_i.adr[`IDCTL_SEL_LSB-1:2];
    assign access   = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
    assign wr_en    = access & wb_req_i.we & wb_req_i.sel[0];

    assign err_link_mask = `NUM_LINKS'(1) << bridge_err_i.link;

    // Write-one-to-clear for the sticky flags
    always_comb begin
        tout_clr = '0;
        inv_clr  = '0;
        if (wr_en && word_idx == `REG_BRIDGE_STAT) begin
            tout_clr = wb_req_i.dat[`NUM_LINKS-1:0];
            inv_clr  = wb_req_i.dat[2*`NUM_LINKS-1:`NUM_LINKS];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read mux
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (word_idx)
            `REG_IDENT:       rdata = `TURF_IDENT;
            `REG_DATEVERSION: rdata = `TURF_DATEVERSION;
            `REG_BRIDGE_CTRL: rdata = `WB_DAT_W'({cfg_q.link, cfg_q.btype});
            `REG_BRIDGE_STAT: rdata = `WB_DAT_W'({inv_flags_q, tout_flags_q});
            `REG_LINK_UP:     rdata = `WB_DAT_W'(link_up_i);
            default:          rdata = '0;
        endcase
    end

    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            ack_q        <= 1'b0;
            cfg_q.btype  <= BRIDGE_NONE;
            cfg_q.link   <= 2'd0;
            tout_flags_q <= '0;
            inv_flags_q  <= '0;
        end else begin
            ack_q <= access;
            if (wr_en && word_idx == `REG_BRIDGE_CTRL) begin
                cfg_q.btype <= bridge_type_e'(wb_req_i.dat[1:0]);
                cfg_q.link  <= wb_req_i.dat[3:2];
            end
            // A new error wins over a clear in the same cycle
            tout_flags_q <= (tout_flags_q & ~tout_clr) |
                            (bridge_err_i.timeout ? err_link_mask : '0);
            inv_flags_q  <= (inv_flags_q & ~inv_clr) |
                            (bridge_err_i.invalid ? err_link_mask : '0);
        end
    end

    // Read data latched with the request
    always_ff @(posedge ps_clk) begin
        if (access) begin
            dat_q <= rdata;
        end
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = dat_q;
    assign bridge_cfg_o = cfg_q;

    // Ack only while the master still holds its request
    assert property (@(posedge ps_clk) disable iff (reset_i)
        wb_rsp_o.ack |-> (wb_req_i.cyc && wb_req_i.stb));

endmodule

// ==== hdl/turf_reg_intercon.sv ====
`timescale 1ns/1ns
`include "turf_regs_cfg.svh"

module turf_reg_intercon
    import turf_regs_pkg::*;
(
    input  logic    ps_clk,
    input  logic    reset_i,
    input  wb_req_t host_req_i,
    output wb_rsp_t host_rsp_o,
    output wb_req_t idctl_req_o,
    input  wb_rsp_t idctl_rsp_i,
    output wb_req_t bridge_req_o,
    input  wb_rsp_t bridge_rsp_i
);

    logic       sel_crate;
    logic       sel_idctl;
    logic       sel_rsvd;
    logic [1:0] region_field;
    logic       rsvd_stb;
    logic       rsvd_ack_q;

    //////////////////////////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////////////////////////

    assign region_field = host_req_i.adr[`IDCTL_SEL_LSB +: 2];
    assign sel_crate    = host_req_i.adr[`CRATE_SEL_BIT];
    assign sel_idctl    = !sel_crate && (region_field == 2'b00);
    assign sel_rsvd     = !sel_crate && (region_field != 2'b00);

    // Slaves see only their own offset
    always_comb begin
        idctl_req_o     = host_req_i;
        idctl_req_o.cyc = host_req_i.cyc & sel_idctl;
        idctl_req_o.stb = host_req_i.stb & sel_idctl;
        idctl_req_o.adr = `WB_ADR_W'(host_req_i.adr[`IDCTL_SEL_LSB-1:0]);

        bridge_req_o     = host_req_i;
        bridge_req_o.cyc = host_req_i.cyc & sel_crate;
        bridge_req_o.stb = host_req_i.stb & sel_crate;
        bridge_req_o.adr = `WB_ADR_W'(host_req_i.adr[`CRATE_SEL_BIT-1:0]);
    end

    //////////////////////////////////////////////////////////////////////
    // Reserved event-control region
    //////////////////////////////////////////////////////////////////////

    assign rsvd_stb = host_req_i.cyc & host_req_i.stb & sel_rsvd;

    // Writes are dropped and reads give zero
    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            rsvd_ack_q <= 1'b0;
        end else begin
            rsvd_ack_q <= rsvd_stb & ~rsvd_ack_q;
        end
    end

    // Response return
    always_comb begin
        host_rsp_o.ack = idctl_rsp_i.ack | bridge_rsp_i.ack | rsvd_ack_q;
        if (sel_crate) begin
            host_rsp_o.dat = bridge_rsp_i.dat;
        end else if (sel_idctl) begin
            host_rsp_o.dat = idctl_rsp_i.dat;
        end else begin
            host_rsp_o.dat = '0;
        end
    end

    // Only one region answers at a time
    assert property (@(posedge ps_clk) disable iff (reset_i)
        $onehot0({idctl_rsp_i.ack, bridge_rsp_i.ack, rsvd_ack_q}));

endmodule

// ==== hdl/turf_regs_cfg.svh ====
`ifndef TURF_REGS_CFG_SVH
`define TURF_REGS_CFG_SVH

// Wishbone widths, host side byte addressed
`define WB_ADR_W 28
`define WB_DAT_W 32

`define NUM_LINKS 4

// Address map
`define CRATE_SEL_BIT 27
`define IDCTL_SEL_LSB 14

// ID/control word offsets
`define REG_IDENT       0
`define REG_DATEVERSION 1
`define REG_BRIDGE_CTRL 2
`define REG_BRIDGE_STAT 3
`define REG_LINK_UP     4

// "TURF" in ASCII
`define TURF_IDENT       32'h54555246
`define TURF_DATEVERSION 32'h0A5B0305

// Crate ack wait, in ps_clk cycles
`define BRIDGE_TIMEOUT 32
`define ERR_DATA       32'hFFFFFFFF

`endif

// ==== hdl/turf_regs_pkg.sv ====
`include "turf_regs_cfg.svh"

package turf_regs_pkg;

    // Wishbone classic request from one master
    typedef struct packed {
        logic                     cyc;
        logic                     stb;
        logic                     we;
        logic [`WB_ADR_W-1:0]     adr;
        logic [`WB_DAT_W-1:0]     dat;
        logic [`WB_DAT_W/8-1:0]   sel;
    } wb_req_t;

    // Wishbone classic response from one slave
    typedef struct packed {
        logic                     ack;
        logic [`WB_DAT_W-1:0]     dat;
    } wb_rsp_t;

    typedef enum logic [1:0] {
        BRIDGE_NONE  = 2'd0,
        BRIDGE_LINK  = 2'd1,
        BRIDGE_RSVD2 = 2'd2,
        BRIDGE_RSVD3 = 2'd3
    } bridge_type_e;

    typedef struct packed {
        bridge_type_e btype;
        logic [1:0]   link;
    } bridge_cfg_t;

    // One-cycle error pulses and the link they refer to
    typedef struct packed {
        logic       timeout;
        logic       invalid;
        logic [1:0] link;
    } bridge_err_t;

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        FORWARD = 2'd1,
        RESPOND = 2'd2
    } bridge_state_e;

endpackage

// ==== hdl/turf_regs_top.sv ====
`timescale 1ns/1ns
`include "turf_regs_cfg.svh"

module turf_regs_top
    import turf_regs_pkg::*;
(
    input  logic                  ps_clk,
    input  logic                  reset_i,
    input  wb_req_t               host_req_i,
    output wb_rsp_t               host_rsp_o,
    output wb_req_t               crate_req_o,
    input  wb_rsp_t               crate_rsp_i,
    input  logic [`NUM_LINKS-1:0] link_up_i
);

    wb_req_t     idctl_req;
    wb_rsp_t     idctl_rsp;
    wb_req_t     bridge_req;
    wb_rsp_t     bridge_rsp;
    bridge_cfg_t bridge_cfg;
    bridge_err_t bridge_err;

    //////////////////////////////////////////////////////////////////////
    // Host decode
    //////////////////////////////////////////////////////////////////////

    turf_reg_intercon u_intercon (
        .ps_clk       (ps_clk),
        .reset_i      (reset_i),
        .host_req_i   (host_req_i),
        .host_rsp_o   (host_rsp_o),
        .idctl_req_o  (idctl_req),
        .idctl_rsp_i  (idctl_rsp),
        .bridge_req_o (bridge_req),
        .bridge_rsp_i (bridge_rsp)
    );

    // Identity and bridge control
    turf_id_ctrl u_idctrl (
        .ps_clk       (ps_clk),
        .reset_i      (reset_i),
        .wb_req_i     (idctl_req),
        .wb_rsp_o     (idctl_rsp),
        .link_up_i    (link_up_i),
        .bridge_err_i (bridge_err),
        .bridge_cfg_o (bridge_cfg)
    );

    // Crate link bridge
    crate_bridge u_bridge (
        .ps_clk       (ps_clk),
        .reset_i      (reset_i),
        .wb_req_i     (bridge_req),
        .wb_rsp_o     (bridge_rsp),
        .bridge_cfg_i (bridge_cfg),
        .link_up_i    (link_up_i),
        .bridge_err_o (bridge_err),
        .crate_req_o  (crate_req_o),
        .crate_rsp_i  (crate_rsp_i)
    );

endmodule

// ==== sim.f ====
+incdir+hdl
hdl/turf_regs_pkg.sv
hdl/turf_reg_intercon.sv
hdl/turf_id_ctrl.sv
hdl/crate_bridge.sv
hdl/turf_regs_top.sv
bench/tb_turf_regs.sv
